// File: isa_pkg.sv
package isa_pkg;

    // architectural data width.
    localparam int XLEN = 32;

    // number of architectural integer registers.
    localparam int NUM_AREGS = 32;

    // data word, also used for program counters.
    typedef logic [XLEN-1:0] word_t;

    // destination register index.
    typedef logic [$clog2(NUM_AREGS)-1:0] areg_t;

endpackage

// File: rob_pkg.sv
package rob_pkg;

    // one instruction as handed over by dispatch.
    typedef struct packed {
        isa_pkg::areg_t dest;  // architectural destination.
        isa_pkg::word_t pc;
    } dispatch_slot_t;

    // one stored reorder buffer entry.
    typedef struct packed {
        logic           done;  // set by writeback.
        isa_pkg::areg_t dest;
        isa_pkg::word_t pc;
        isa_pkg::word_t result;
    } rob_entry_t;

    // one retiring instruction on the commit side.
    // same fields as an entry, minus the done flag, since
    // only completed entries ever leave the queue.
    typedef struct packed {
        isa_pkg::areg_t dest;
        isa_pkg::word_t pc;
        isa_pkg::word_t result;
    } commit_slot_t;

endpackage

// File: dispatch_intake.sv
module dispatch_intake #(
    parameter int LANES = 4,
    parameter int DEPTH = 16
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   disp_req,
    input  logic [$clog2(LANES+1)-1:0]             disp_count,
    input  rob_pkg::dispatch_slot_t [LANES-1:0]    disp_slots,
    input  logic [$clog2(DEPTH):0]                 free_slots,
    input  logic [$clog2(DEPTH)-1:0]               tail_tag,
    output logic                                   disp_ack,
    output logic [LANES-1:0][$clog2(DEPTH)-1:0]    alloc_tags,
    output logic                                   push,
    output logic [$clog2(LANES+1)-1:0]             push_count,
    output rob_pkg::dispatch_slot_t [LANES-1:0]    push_slots
);

    localparam int TW = $clog2(DEPTH);

    typedef enum logic {
        ST_WAIT,
        ST_ACK
    } state_t;

    state_t state;
    logic   has_room;

    // whole bundle must fit, no partial allocation.
    assign has_room = free_slots >= disp_count;

    // push on the same edge that raises the ack.
    assign push       = (state == ST_WAIT) && disp_req && has_room;
    assign push_count = disp_count;
    assign push_slots = disp_slots;

    assign disp_ack = (state == ST_ACK);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_WAIT;
        end else begin
            case (state)
                ST_WAIT: begin
                    if (push) begin
                        state <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (!disp_req) begin  // source has seen the ack.
                        state <= ST_WAIT;
                    end
                end
                default: state <= ST_WAIT;
            endcase
        end
    end

    // tags follow the queue tail, one per lane.
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < LANES; i++) begin
                alloc_tags[i] <= tail_tag + TW'(i);  // wraps mod DEPTH.
            end
        end
    end

    // four-phase rule, ack only falls after req is gone.
    a_ack_held: assert property (
        @(posedge clk) disable iff (rst)
        disp_ack && disp_req |=> disp_ack
    ) else $error("disp_ack fell while disp_req high");

    // source must offer a sensible bundle size.
    a_count_range: assert property (
        @(posedge clk) disable iff (rst)
        disp_req |-> (disp_count != 0) && (disp_count <= LANES)
    ) else $error("disp_count out of range");

endmodule

// File: rob_queue.sv
module rob_queue #(
    parameter int DEPTH = 16,
    parameter int LANES = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   push,
    input  logic [$clog2(LANES+1)-1:0]             push_count,
    input  rob_pkg::dispatch_slot_t [LANES-1:0]    push_slots,
    input  logic                                   pop,
    input  logic [$clog2(LANES+1)-1:0]             pop_count,
    input  logic [LANES-1:0]                       wb_valid,
    input  logic [LANES-1:0][$clog2(DEPTH)-1:0]    wb_tag,
    input  isa_pkg::word_t [LANES-1:0]             wb_result,
    output logic [$clog2(DEPTH):0]                 free_slots,
    output logic [$clog2(DEPTH)-1:0]               tail_tag,
    output rob_pkg::rob_entry_t [LANES-1:0]        head_entries,
    output logic [LANES-1:0]                       head_valid
);

    localparam int TW = $clog2(DEPTH);
    localparam int PW = TW + 1;

    rob_pkg::rob_entry_t mem [DEPTH];

    // extra msb tells a full queue from an empty one.
    logic [PW-1:0] head;
    logic [PW-1:0] tail;
    logic [PW-1:0] occupancy;

    logic [TW-1:0] head_idx;
    logic [TW-1:0] tail_idx;

    logic [LANES-1:0][TW-1:0] push_idx;
    logic [LANES-1:0]         wb_live;

    assign head_idx  = head[TW-1:0];
    assign tail_idx  = tail[TW-1:0];
    assign occupancy = tail - head;

    assign free_slots = PW'(DEPTH) - occupancy;
    assign tail_tag   = tail_idx;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            push_idx[i]     = tail_idx + TW'(i);
            head_entries[i] = mem[head_idx + TW'(i)];  // oldest first.
            head_valid[i]   = PW'(i) < occupancy;
        end
    end

    // distance from head, mod DEPTH, must land inside the occupied span.
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            wb_live[i] = {1'b0, wb_tag[i] - head_idx} < occupancy;
        end
    end

    // pointers, push and pop may share an edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (push) begin
                tail <= tail + PW'(push_count);
            end
            if (pop) begin
                head <= head + PW'(pop_count);
            end
        end
    end

    // entry storage.
    // pushes land on free slots and writebacks on occupied ones,
    // so the two never collide on the same index.
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < LANES; i++) begin
                if (i < push_count) begin
                    mem[push_idx[i]].done <= 1'b0;
                    mem[push_idx[i]].dest <= push_slots[i].dest;
                    mem[push_idx[i]].pc   <= push_slots[i].pc;
                end
            end
        end
        for (int i = 0; i < LANES; i++) begin
            if (wb_valid[i]) begin
                mem[wb_tag[i]].done   <= 1'b1;
                mem[wb_tag[i]].result <= wb_result[i];
            end
        end
    end

    // intake must have checked space before pushing.
    a_push_fits: assert property (
        @(posedge clk) disable iff (rst)
        push |-> PW'(push_count) <= free_slots
    ) else $error("push exceeds free space");

    // commit side pops only what it saw in the head window.
    a_pop_fits: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> PW'(pop_count) <= occupancy
    ) else $error("pop exceeds occupancy");

    a_wb_live: assert property (
        @(posedge clk) disable iff (rst)
        (wb_valid & ~wb_live) == '0
    ) else $error("writeback to unoccupied entry");

endmodule

// File: commit_stage.sv
module commit_stage #(
    parameter int LANES = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  rob_pkg::rob_entry_t [LANES-1:0]      head_entries,
    input  logic [LANES-1:0]                     head_valid,
    input  logic                                 commit_ack,
    output logic                                 commit_req,
    output logic [$clog2(LANES+1)-1:0]           commit_count,
    output rob_pkg::commit_slot_t [LANES-1:0]    commit_slots,
    output logic                                 pop,
    output logic [$clog2(LANES+1)-1:0]           pop_count
);

    localparam int CW = $clog2(LANES+1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_DRAIN
    } state_t;

    state_t         state;
    logic [LANES-1:0] ready;  // occupied and written back.
    logic [CW-1:0]  lead_count;
    logic           start;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            ready[i] = head_valid[i] && head_entries[i].done;
        end
    end

    // length of the unbroken run of ready entries from the head.
    // scanning downward, the last hole seen is the lowest one.
    always_comb begin
        lead_count = CW'(LANES);
        for (int i = LANES - 1; i >= 0; i--) begin
            if (!ready[i]) begin
                lead_count = CW'(i);
            end
        end
    end

    assign start = (state == ST_IDLE) && ready[0];

    assign commit_req = (state == ST_REQ);
    assign pop        = (state == ST_REQ) && commit_ack;  // free on accept.
    assign pop_count  = commit_count;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= ST_IDLE;
            commit_count <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state        <= ST_REQ;
                        commit_count <= lead_count;
                    end
                end
                ST_REQ: begin
                    if (commit_ack) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    // head window has settled by the time ack drops.
                    if (!commit_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // bundle payload stays frozen until the next scan.
    always_ff @(posedge clk) begin
        if (start) begin
            for (int i = 0; i < LANES; i++) begin
                commit_slots[i].dest   <= head_entries[i].dest;
                commit_slots[i].pc     <= head_entries[i].pc;
                commit_slots[i].result <= head_entries[i].result;
            end
        end
    end

    // offer holds steady under back-pressure.
    a_req_held: assert property (
        @(posedge clk) disable iff (rst)
        commit_req && !commit_ack |=>
            commit_req && $stable(commit_count) && $stable(commit_slots)
    ) else $error("commit offer changed before ack");

endmodule

// File: rob_top.sv
module rob_top #(
    parameter int DEPTH = 16,
    parameter int LANES = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    // dispatch handshake.
    input  logic                                   disp_req,
    input  logic [$clog2(LANES+1)-1:0]             disp_count,
    input  rob_pkg::dispatch_slot_t [LANES-1:0]    disp_slots,
    output logic                                   disp_ack,
    output logic [LANES-1:0][$clog2(DEPTH)-1:0]    alloc_tags,
    // writeback ports.
    input  logic [LANES-1:0]                       wb_valid,
    input  logic [LANES-1:0][$clog2(DEPTH)-1:0]    wb_tag,
    input  isa_pkg::word_t [LANES-1:0]             wb_result,
    // commit handshake.
    output logic                                   commit_req,
    output logic [$clog2(LANES+1)-1:0]             commit_count,
    output rob_pkg::commit_slot_t [LANES-1:0]      commit_slots,
    input  logic                                   commit_ack
);

    localparam int TW = $clog2(DEPTH);
    localparam int CW = $clog2(LANES+1);

    logic                                push;
    logic [CW-1:0]                       push_count;
    rob_pkg::dispatch_slot_t [LANES-1:0] push_slots;
    logic [TW:0]                         free_slots;
    logic [TW-1:0]                       tail_tag;

    rob_pkg::rob_entry_t [LANES-1:0]     head_entries;
    logic [LANES-1:0]                    head_valid;
    logic                                pop;
    logic [CW-1:0]                       pop_count;

    dispatch_intake #(
        .LANES (LANES),
        .DEPTH (DEPTH)
    ) dispatch_intake_inst (
        .clk        (clk),
        .rst        (rst),
        .disp_req   (disp_req),
        .disp_count (disp_count),
        .disp_slots (disp_slots),
        .free_slots (free_slots),
        .tail_tag   (tail_tag),
        .disp_ack   (disp_ack),
        .alloc_tags (alloc_tags),
        .push       (push),
        .push_count (push_count),
        .push_slots (push_slots)
    );

    rob_queue #(
        .DEPTH (DEPTH),
        .LANES (LANES)
    ) rob_queue_inst (
        .clk          (clk),
        .rst          (rst),
        .push         (push),
        .push_count   (push_count),
        .push_slots   (push_slots),
        .pop          (pop),
        .pop_count    (pop_count),
        .wb_valid     (wb_valid),
        .wb_tag       (wb_tag),
        .wb_result    (wb_result),
        .free_slots   (free_slots),
        .tail_tag     (tail_tag),
        .head_entries (head_entries),
        .head_valid   (head_valid)
    );

    commit_stage #(
        .LANES (LANES)
    ) commit_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .head_entries (head_entries),
        .head_valid   (head_valid),
        .commit_ack   (commit_ack),
        .commit_req   (commit_req),
        .commit_count (commit_count),
        .commit_slots (commit_slots),
        .pop          (pop),
        .pop_count    (pop_count)
    );

endmodule

// File: tb_rob_top.sv
module tb_rob_top;

    localparam int DEPTH      = 16;
    localparam int LANES      = 4;
    localparam int TW         = $clog2(DEPTH);
    localparam int CW         = $clog2(LANES+1);
    localparam int TOTAL      = 200;
    localparam int MAX_CYCLES = TOTAL * 40;
    localparam int CHECK_W    = 320;  // wide enough for a whole commit bundle.

    logic                                clk = 1'b0;
    logic                                rst;
    logic                                disp_req;
    logic [CW-1:0]                       disp_count;
    rob_pkg::dispatch_slot_t [LANES-1:0] disp_slots;
    logic                                disp_ack;
    logic [LANES-1:0][TW-1:0]            alloc_tags;
    logic [LANES-1:0]                    wb_valid;
    logic [LANES-1:0][TW-1:0]            wb_tag;
    isa_pkg::word_t [LANES-1:0]          wb_result;
    logic                                commit_req;
    logic [CW-1:0]                       commit_count;
    rob_pkg::commit_slot_t [LANES-1:0]   commit_slots;
    logic                                commit_ack;

    // reference model, indexed by program order.
    isa_pkg::areg_t exp_dest [TOTAL];
    isa_pkg::word_t exp_pc [TOTAL];
    isa_pkg::word_t exp_result [TOTAL];
    logic           written [TOTAL];
    int             alloc_seq;
    int             commit_seq;
    int             outstanding;

    logic [31:0]                       lfsr;
    logic                              hold_commits;  // starve the commit side to fill the ROB.
    logic                              saw_full;
    logic                              offer_seen;
    int                                full_wait;
    int                                ack_delay;
    int                                cycles;
    logic [CW-1:0]                     held_count;
    rob_pkg::commit_slot_t [LANES-1:0] held_slots;

    rob_top #(
        .DEPTH (DEPTH),
        .LANES (LANES)
    ) rob_top_inst (
        .clk          (clk),
        .rst          (rst),
        .disp_req     (disp_req),
        .disp_count   (disp_count),
        .disp_slots   (disp_slots),
        .disp_ack     (disp_ack),
        .alloc_tags   (alloc_tags),
        .wb_valid     (wb_valid),
        .wb_tag       (wb_tag),
        .wb_result    (wb_result),
        .commit_req   (commit_req),
        .commit_count (commit_count),
        .commit_slots (commit_slots),
        .commit_ack   (commit_ack)
    );

    always #50 clk = ~clk;

    // galois form with taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [CHECK_W-1:0] expected,
                         input logic [CHECK_W-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "check %s failed", name);
        end
    endtask

    task automatic accept_commits();
        int n;
        if (commit_ack) begin
            if (!commit_req) begin  // req has gone, so close the handshake.
                commit_ack = 1'b0;
                offer_seen = 1'b0;
            end
        end else if (commit_req && !offer_seen) begin
            n = int'(commit_count);
            check("commit_count_min", 1, CHECK_W'(n >= 1));
            check("commit_count_max", 1, CHECK_W'(n <= LANES && n <= outstanding));
            for (int i = 0; i < n; i++) begin
                check("written_before_commit", 1, CHECK_W'(written[commit_seq + i]));
                check("commit_dest", CHECK_W'(exp_dest[commit_seq + i]),
                      CHECK_W'(commit_slots[i].dest));
                check("commit_pc", CHECK_W'(exp_pc[commit_seq + i]),
                      CHECK_W'(commit_slots[i].pc));
                check("commit_result", CHECK_W'(exp_result[commit_seq + i]),
                      CHECK_W'(commit_slots[i].result));
            end
            held_count = commit_count;
            held_slots = commit_slots;
            offer_seen = 1'b1;
            ack_delay  = int'(rand_bits(2));
        end else if (offer_seen) begin
            check("held_req", 1, CHECK_W'(commit_req));
            check("held_count", CHECK_W'(held_count), CHECK_W'(commit_count));
            check("held_slots", CHECK_W'(held_slots), CHECK_W'(commit_slots));
            if (!hold_commits) begin
                if (ack_delay == 0) begin
                    commit_ack   = 1'b1;
                    commit_seq  += int'(held_count);
                    outstanding -= int'(held_count);
                end else begin
                    ack_delay--;
                end
            end
        end
    endtask

    task automatic send_dispatch();
        int n;
        if (disp_req && disp_ack) begin
            n = int'(disp_count);
            check("no_reissue", 1, CHECK_W'(outstanding + n <= DEPTH));
            for (int i = 0; i < n; i++) begin
                check("alloc_tag", CHECK_W'((alloc_seq + i) % DEPTH), CHECK_W'(alloc_tags[i]));
                exp_dest[alloc_seq + i] = disp_slots[i].dest;
                exp_pc[alloc_seq + i]   = disp_slots[i].pc;
            end
            alloc_seq   += n;
            outstanding += n;
            disp_req     = 1'b0;
        end else if (disp_req) begin
            // stalled for space while commits are withheld.
            if (hold_commits && outstanding + int'(disp_count) > DEPTH) begin
                saw_full = 1'b1;
                full_wait++;
                if (full_wait >= 6) begin
                    hold_commits = 1'b0;
                end
            end
        end else if (!disp_ack && alloc_seq < TOTAL && rand_bits(2) != 0) begin
            n = 1 + int'(rand_bits(2));
            if (n > TOTAL - alloc_seq) begin
                n = TOTAL - alloc_seq;
            end
            disp_count = CW'(n);
            for (int i = 0; i < LANES; i++) begin
                disp_slots[i].dest = isa_pkg::areg_t'(rand_bits(5));
                disp_slots[i].pc   = rand_bits(32);
            end
            disp_req = 1'b1;
        end
    endtask

    // random out-of-order completion within the live window.
    task automatic complete_writebacks();
        int seq;
        wb_valid = '0;
        for (int i = 0; i < LANES; i++) begin
            seq = commit_seq + int'(rand_bits(4));
            if (seq < alloc_seq && !written[seq] && rand_bits(1) != 0) begin
                written[seq]    = 1'b1;
                exp_result[seq] = rand_bits(32);
                wb_valid[i]     = 1'b1;
                wb_tag[i]       = TW'(seq % DEPTH);
                wb_result[i]    = exp_result[seq];
            end
        end
    endtask

    initial begin
        lfsr         = 32'h3244_cfc9;
        rst          = 1'b1;
        disp_req     = 1'b0;
        disp_count   = '0;
        disp_slots   = '0;
        wb_valid     = '0;
        wb_tag       = '0;
        wb_result    = '0;
        commit_ack   = 1'b0;
        alloc_seq    = 0;
        commit_seq   = 0;
        outstanding  = 0;
        hold_commits = 1'b1;
        saw_full     = 1'b0;
        offer_seen   = 1'b0;
        full_wait    = 0;
        ack_delay    = 0;
        cycles       = 0;
        held_count   = '0;
        held_slots   = '0;
        for (int i = 0; i < TOTAL; i++) begin
            written[i] = 1'b0;
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        check("reset_disp_ack", 0, CHECK_W'(disp_ack));
        check("reset_commit_req", 0, CHECK_W'(commit_req));
        while (commit_seq < TOTAL) begin
            @(negedge clk);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                $display("SIMULATION FAILED");
                $fatal(1, "simulation timed out after %0d cycles", cycles);
            end else begin
                accept_commits();
                send_dispatch();
                complete_writebacks();
            end
        end
        if (!saw_full) begin
            $display("SIMULATION FAILED");
            $fatal(1, "the ROB never filled while commits were withheld");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// File: vlog.f
isa_pkg.sv
rob_pkg.sv
dispatch_intake.sv
rob_queue.sv
commit_stage.sv
rob_top.sv
tb_rob_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ROB testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rob_top -f vlog.f -o tb_rob_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_rob_top
status=$?
if [ $status -ne 0 ]; then
    echo "simulation run ended with status $status"
    exit $status
fi

exit 0
